//--- design/clip_pkg.sv
// clip stage package with stream widths, types, flux count and register map
package clip_pkg;

    // stream geometry
    localparam int FLUX         = 2;
    localparam int TAG_WIDTH    = (FLUX > 1) ? $clog2(FLUX) : 1;
    localparam int FIFO_DEPTH   = 4;
    localparam int SAMPLE_WIDTH = 16;
    localparam int PEL_WIDTH    = 8;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [PEL_WIDTH-1:0]           pel_t;
    typedef logic [TAG_WIDTH-1:0]           tag_t;
    typedef logic [FLUX-1:0]                flux_mask_t;
    typedef logic [15:0]                    sat_count_t;

    // AXI4-Lite widths
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // register map
    localparam axi_addr_t REG_CTRL    = 4'h0;
    localparam axi_addr_t REG_CLIP_LO = 4'h4;
    localparam axi_addr_t REG_CLIP_HI = 4'h8;
    localparam axi_addr_t REG_SAT_CNT = 4'hC;

    // reset values, all fluxes on and full pel range
    localparam flux_mask_t CTRL_RESET    = '1;
    localparam pel_t       CLIP_LO_RESET = 8'd0;
    localparam pel_t       CLIP_HI_RESET = 8'd255;

endpackage

//--- design/pel_fifo.sv
// pel FIFO that buffers one flux with a show-ahead head and registered flags
module pel_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             write,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             read,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    // storage, no reset needed on the payload
    logic [WIDTH-1:0] mem [DEPTH];

    // pointers wrap naturally since DEPTH is a power of two
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic [$clog2(DEPTH+1)-1:0] count_next;

    logic do_write;
    logic do_read;

    // writes while full and reads while empty are dropped
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    always_comb
    begin
        count_next = count;
        if (do_write && !do_read)
            count_next = count + 1'b1;
        else if (do_read && !do_write)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            // flags follow the next occupancy so they stay registered
            empty <= (count_next == 0);
            full  <= (count_next == DEPTH);
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= din;
    end

    // head entry shows without a read
    assign dout = mem[rd_ptr];

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= DEPTH);

endmodule

//--- design/clip_actor.sv
// clip actor that picks the lowest ready flux and saturates its sample to a pel
module clip_actor (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  clip_pkg::flux_mask_t                   in_empty,
    input  clip_pkg::sample_t [clip_pkg::FLUX-1:0] in_head,
    output clip_pkg::flux_mask_t                   in_read,
    input  clip_pkg::flux_mask_t                   out_full,
    output clip_pkg::flux_mask_t                   out_write,
    output clip_pkg::pel_t                         out_pel,
    input  clip_pkg::flux_mask_t                   enable,
    input  clip_pkg::pel_t                         clip_lo,
    input  clip_pkg::pel_t                         clip_hi,
    output logic                                   sat_pulse
);

    import clip_pkg::*;

    flux_mask_t ready;
    tag_t       win;
    logic       found;
    sample_t    head_sel;
    sample_t    lo_ext;
    sample_t    hi_ext;
    logic       clip_hit;

    // a flux can move when enabled, holding data and with room downstream
    assign ready = enable & ~in_empty & ~out_full;

    // priority search, walking down so the lowest index is kept last
    always_comb
    begin
        found = 1'b0;
        win   = '0;
        for (int i = FLUX - 1; i >= 0; i--)
        begin
            if (ready[i])
            begin
                found = 1'b1;
                win   = tag_t'(i);
            end
        end
    end

    assign head_sel = in_head[win];

    // bounds widened to signed 16 bits for the compare
    assign lo_ext = {8'h00, clip_lo};
    assign hi_ext = {8'h00, clip_hi};

    // upper test first, so crossed bounds resolve to clip_hi
    always_comb
    begin
        if (head_sel > hi_ext)
        begin
            out_pel  = clip_hi;
            clip_hit = 1'b1;
        end
        else if (head_sel < lo_ext)
        begin
            out_pel  = clip_lo;
            clip_hit = 1'b1;
        end
        else
        begin
            out_pel  = head_sel[PEL_WIDTH-1:0];
            clip_hit = 1'b0;
        end
    end

    assign in_read   = found ? (flux_mask_t'(1) << win) : '0;
    // lowest set bit of ready, an independent path to the same winner
    assign out_write = ready & (~ready + 1'b1);
    assign sat_pulse = found && clip_hit;

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(out_write));

    a_strobe_match: assert property (@(posedge clk) disable iff (!rst_n)
        in_read == out_write);

endmodule

//--- design/clip_regs.sv
// AXI4-Lite register block with enable mask, clip bounds and saturation counter
module clip_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  clip_pkg::axi_addr_t   awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  clip_pkg::axi_data_t   wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output clip_pkg::axi_resp_t   bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  clip_pkg::axi_addr_t   araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output clip_pkg::axi_data_t   rdata,
    output clip_pkg::axi_resp_t   rresp,
    input  logic                  sat_pulse,
    output clip_pkg::flux_mask_t  enable,
    output clip_pkg::pel_t        clip_lo,
    output clip_pkg::pel_t        clip_hi
);

    import clip_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WAIT_DATA,
        WR_WAIT_ADDR,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_t;

    wr_state_t  wr_state;
    rd_state_t  rd_state;
    axi_addr_t  aw_addr_q;
    axi_data_t  w_data_q;
    logic [3:0] w_strb_q;
    axi_addr_t  wr_addr;
    axi_data_t  wr_data;
    logic [3:0] wr_strb;
    logic       wr_fire;
    axi_data_t  rd_mux;
    axi_data_t  rdata_q;
    sat_count_t sat_cnt;

    assign awready = (wr_state == WR_IDLE) || (wr_state == WR_WAIT_ADDR);
    assign wready  = (wr_state == WR_IDLE) || (wr_state == WR_WAIT_DATA);
    assign bvalid  = (wr_state == WR_RESP);
    assign bresp   = RESP_OKAY;

    // merge live and captured halves into one register write
    always_comb
    begin
        wr_fire = 1'b0;
        wr_addr = aw_addr_q;
        wr_data = w_data_q;
        wr_strb = w_strb_q;
        case (wr_state)
            WR_IDLE:
            begin
                wr_addr = awaddr;
                wr_data = wdata;
                wr_strb = wstrb;
                wr_fire = awvalid && wvalid;
            end
            WR_WAIT_DATA:
            begin
                wr_data = wdata;
                wr_strb = wstrb;
                wr_fire = wvalid;
            end
            WR_WAIT_ADDR:
            begin
                wr_addr = awaddr;
                wr_fire = awvalid;
            end
            default:
            begin
                wr_fire = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wr_state <= WR_IDLE;
        else if (wr_fire)
            wr_state <= WR_RESP;
        else if (wr_state == WR_IDLE && awvalid)
            wr_state <= WR_WAIT_DATA;
        else if (wr_state == WR_IDLE && wvalid)
            wr_state <= WR_WAIT_ADDR;
        else if (wr_state == WR_RESP && bready)
            wr_state <= WR_IDLE;
    end

    // hold whichever half arrived first
    always_ff @(posedge clk)
    begin
        if (wr_state == WR_IDLE && awvalid)
            aw_addr_q <= awaddr;
        if (wr_state == WR_IDLE && wvalid)
        begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            enable  <= CTRL_RESET;
            clip_lo <= CLIP_LO_RESET;
            clip_hi <= CLIP_HI_RESET;
        end
        else if (wr_fire && wr_strb[0])
        begin
            case (wr_addr)
                REG_CTRL:    enable  <= wr_data[FLUX-1:0];
                REG_CLIP_LO: clip_lo <= wr_data[PEL_WIDTH-1:0];
                REG_CLIP_HI: clip_hi <= wr_data[PEL_WIDTH-1:0];
                default:     enable  <= enable;
            endcase
        end
    end

    // clear on any write, otherwise count up and stick at the top
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            sat_cnt <= '0;
        else if (wr_fire && wr_addr == REG_SAT_CNT)
            sat_cnt <= '0;
        else if (sat_pulse && sat_cnt != '1)
            sat_cnt <= sat_cnt + 1'b1;
    end

    always_comb
    begin
        case (araddr)
            REG_CTRL:    rd_mux = axi_data_t'(enable);
            REG_CLIP_LO: rd_mux = axi_data_t'(clip_lo);
            REG_CLIP_HI: rd_mux = axi_data_t'(clip_hi);
            REG_SAT_CNT: rd_mux = axi_data_t'(sat_cnt);
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_state <= RD_IDLE;
        else if (rd_state == RD_IDLE && arvalid)
            rd_state <= RD_RESP;
        else if (rd_state == RD_RESP && rready)
            rd_state <= RD_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (rd_state == RD_IDLE && arvalid)
            rdata_q <= rd_mux;
    end

    assign arready = (rd_state == RD_IDLE);
    assign rvalid  = (rd_state == RD_RESP);
    assign rdata   = rdata_q;
    assign rresp   = RESP_OKAY;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- design/clip_top.sv
// clip subsystem top tying stream FIFOs, the clip actor and its registers together
module clip_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  clip_pkg::flux_mask_t                   in_write,
    input  clip_pkg::sample_t [clip_pkg::FLUX-1:0] in_din,
    output clip_pkg::flux_mask_t                   in_full,
    input  clip_pkg::flux_mask_t                   out_read,
    output clip_pkg::pel_t [clip_pkg::FLUX-1:0]    out_dout,
    output clip_pkg::flux_mask_t                   out_empty,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  clip_pkg::axi_addr_t                    awaddr,
    input  logic                                   wvalid,
    output logic                                   wready,
    input  clip_pkg::axi_data_t                    wdata,
    input  logic [3:0]                             wstrb,
    output logic                                   bvalid,
    input  logic                                   bready,
    output clip_pkg::axi_resp_t                    bresp,
    input  logic                                   arvalid,
    output logic                                   arready,
    input  clip_pkg::axi_addr_t                    araddr,
    output logic                                   rvalid,
    input  logic                                   rready,
    output clip_pkg::axi_data_t                    rdata,
    output clip_pkg::axi_resp_t                    rresp
);

    import clip_pkg::*;

    flux_mask_t            in_empty;
    sample_t [FLUX-1:0]    in_head;
    flux_mask_t            act_read;
    flux_mask_t            act_write;
    flux_mask_t            out_full;
    pel_t                  act_pel;
    flux_mask_t            enable;
    pel_t                  clip_lo;
    pel_t                  clip_hi;
    logic                  sat_pulse;

    // one input and one output queue per flux
    for (genvar g = 0; g < FLUX; g++)
    begin : g_flux
        pel_fifo #(
            .WIDTH (SAMPLE_WIDTH),
            .DEPTH (FIFO_DEPTH)
        ) u_in_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .write (in_write[g]),
            .din   (in_din[g]),
            .full  (in_full[g]),
            .read  (act_read[g]),
            .dout  (in_head[g]),
            .empty (in_empty[g])
        );

        // the shared pel lands only where the write strobe points
        pel_fifo #(
            .WIDTH (PEL_WIDTH),
            .DEPTH (FIFO_DEPTH)
        ) u_out_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .write (act_write[g]),
            .din   (act_pel),
            .full  (out_full[g]),
            .read  (out_read[g]),
            .dout  (out_dout[g]),
            .empty (out_empty[g])
        );
    end

    clip_actor u_actor (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_empty  (in_empty),
        .in_head   (in_head),
        .in_read   (act_read),
        .out_full  (out_full),
        .out_write (act_write),
        .out_pel   (act_pel),
        .enable    (enable),
        .clip_lo   (clip_lo),
        .clip_hi   (clip_hi),
        .sat_pulse (sat_pulse)
    );

    clip_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .sat_pulse (sat_pulse),
        .enable    (enable),
        .clip_lo   (clip_lo),
        .clip_hi   (clip_hi)
    );

endmodule

//--- bench/clip_checker.sv
// scoreboard for the clip subsystem that predicts pels per flux and checks every pop
module clip_checker (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  clip_pkg::flux_mask_t                   in_write,
    input  clip_pkg::sample_t [clip_pkg::FLUX-1:0] in_din,
    input  clip_pkg::flux_mask_t                   in_full,
    input  clip_pkg::flux_mask_t                   out_read,
    input  clip_pkg::pel_t [clip_pkg::FLUX-1:0]    out_dout,
    input  clip_pkg::flux_mask_t                   out_empty,
    input  logic                                   awvalid,
    input  logic                                   awready,
    input  clip_pkg::axi_addr_t                    awaddr,
    input  logic                                   wvalid,
    input  logic                                   wready,
    input  clip_pkg::axi_data_t                    wdata,
    input  logic [3:0]                             wstrb,
    input  logic                                   finish_req,
    output clip_pkg::flux_mask_t                   busy,
    output clip_pkg::sat_count_t                   sat_expected,
    output int                                     err_count
);

    import clip_pkg::*;

    // one queue of predicted pels per flux
    pel_t      exp_q [FLUX][$];
    pel_t      lo_m;
    pel_t      hi_m;
    logic      aw_seen;
    logic      w_seen;
    axi_addr_t aw_addr_m;
    axi_data_t w_data_m;
    logic [3:0] w_strb_m;
    logic      finished;

    // upper bound tested first, compare done on signed integers
    function automatic pel_t expected_pel(input sample_t s, input pel_t lo, input pel_t hi);
        int v;
        v = s;
        if (v > int'(hi))
            return hi;
        if (v < int'(lo))
            return lo;
        return pel_t'(v);
    endfunction

    always @(posedge clk)
    begin
        sample_t s;
        pel_t    p;
        pel_t    got;
        if (!rst_n)
        begin
            for (int f = 0; f < FLUX; f++)
                exp_q[f].delete();
            lo_m         = 8'd0;
            hi_m         = 8'd255;
            aw_seen      = 1'b0;
            w_seen       = 1'b0;
            finished     = 1'b0;
            busy         = '0;
            sat_expected = '0;
            err_count    = 0;
        end
        else
        begin
            for (int f = 0; f < FLUX; f++)
            begin
                if (in_write[f] && !in_full[f])
                begin
                    s = in_din[f];
                    p = expected_pel(s, lo_m, hi_m);
                    exp_q[f].push_back(p);
                    // a sample the clip changed counts once
                    if (int'(s) != int'(p) && sat_expected != 16'hFFFF)
                        sat_expected++;
                end
                if (out_read[f] && !out_empty[f])
                begin
                    got = out_dout[f];
                    if (exp_q[f].size() == 0)
                    begin
                        $display("error at %0t: flux %0d popped pel %0d that was never sent",
                                 $time, f, got);
                        err_count++;
                    end
                    else
                    begin
                        p = exp_q[f].pop_front();
                        if (got != p)
                        begin
                            $display("mismatch at %0t: out_dout[%0d] got %0d expected %0d",
                                     $time, f, got, p);
                            err_count++;
                        end
                    end
                end
                busy[f] = (exp_q[f].size() != 0);
            end

            // register writes land once both halves are accepted
            if (awvalid && awready)
            begin
                aw_seen   = 1'b1;
                aw_addr_m = awaddr;
            end
            if (wvalid && wready)
            begin
                w_seen   = 1'b1;
                w_data_m = wdata;
                w_strb_m = wstrb;
            end
            if (aw_seen && w_seen)
            begin
                if (aw_addr_m == REG_CLIP_LO && w_strb_m[0])
                    lo_m = w_data_m[7:0];
                else if (aw_addr_m == REG_CLIP_HI && w_strb_m[0])
                    hi_m = w_data_m[7:0];
                else if (aw_addr_m == REG_SAT_CNT)
                    sat_expected = '0;
                aw_seen = 1'b0;
                w_seen  = 1'b0;
            end

            if (finish_req && !finished)
            begin
                finished = 1'b1;
                for (int f = 0; f < FLUX; f++)
                begin
                    if (exp_q[f].size() != 0)
                    begin
                        $display("error: flux %0d ends with %0d pels that never came out",
                                 f, exp_q[f].size());
                        err_count++;
                    end
                end
            end
        end
    end

endmodule

//--- bench/clip_tb.sv
// testbench for the clip subsystem, table driven with a watchdog
module clip_tb;

    import clip_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int N_ENTRIES       = 31;
    localparam int N_RANDOM        = 48;
    localparam int WATCHDOG_CYCLES = (N_ENTRIES + N_RANDOM) * 40 + 500;
    localparam int WAIT_LIMIT      = 200;

    localparam int PH_DEFAULT      = 0;
    localparam int PH_BOUNDS       = 1;
    localparam int PH_CROSSED      = 2;
    localparam int PH_MASKED       = 3;
    localparam int PH_BACKPRESSURE = 4;

    // one row per sample, columns are flux, sample value and phase
    localparam int TBL_FLUX [N_ENTRIES] = '{
        0, 1, 0, 1, 0, 1, 0, 1,
        0, 1, 0, 1, 0, 1,
        0, 1, 0, 1,
        1, 0, 1, 0, 1,
        0, 0, 0, 0, 0, 0, 0, 0};
    localparam int TBL_SAMPLE [N_ENTRIES] = '{
        -128, -1, 0, 100, 255, 256, 32767, -32768,
        15, 16, 128, 235, 236, -5,
        50, 150, 100, 200,
        10, 40, 20, 50, 30,
        11, 22, 33, 44, 55, 66, 77, 88};
    localparam int TBL_PHASE [N_ENTRIES] = '{
        0, 0, 0, 0, 0, 0, 0, 0,
        1, 1, 1, 1, 1, 1,
        2, 2, 2, 2,
        3, 3, 3, 3, 3,
        4, 4, 4, 4, 4, 4, 4, 4};

    logic               clk = 1'b0;
    logic               rst_n;
    flux_mask_t         in_write;
    sample_t [FLUX-1:0] in_din;
    flux_mask_t         in_full;
    flux_mask_t         out_read;
    pel_t [FLUX-1:0]    out_dout;
    flux_mask_t         out_empty;
    logic               awvalid;
    logic               awready;
    axi_addr_t          awaddr;
    logic               wvalid;
    logic               wready;
    axi_data_t          wdata;
    logic [3:0]         wstrb;
    logic               bvalid;
    logic               bready;
    axi_resp_t          bresp;
    logic               arvalid;
    logic               arready;
    axi_addr_t          araddr;
    logic               rvalid;
    logic               rready;
    axi_data_t          rdata;
    axi_resp_t          rresp;
    flux_mask_t         busy;
    sat_count_t         sat_expected;
    int                 chk_errors;
    logic               finish_req;
    int                 tb_errors;
    logic [31:0]        lcg_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    clip_top UUT (
        .clk (clk), .rst_n (rst_n),
        .in_write (in_write), .in_din (in_din), .in_full (in_full),
        .out_read (out_read), .out_dout (out_dout), .out_empty (out_empty),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    clip_checker chk (
        .clk (clk), .rst_n (rst_n),
        .in_write (in_write), .in_din (in_din), .in_full (in_full),
        .out_read (out_read), .out_dout (out_dout), .out_empty (out_empty),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .finish_req (finish_req), .busy (busy),
        .sat_expected (sat_expected), .err_count (chk_errors)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic note_failure(input string what);
        $display("error at %0t: %s", $time, what);
        tb_errors++;
    endtask

    task automatic compare_value(input string name, input int got, input int expected);
        if (got != expected)
        begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
            tb_errors++;
        end
    endtask

    // all tasks below start and end on a falling edge
    task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input int lead);
        int   n;
        logic aw_done;
        logic w_done;
        n       = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        // lead 1 sends the address a cycle early, lead 2 the data
        awvalid = (lead != 2);
        wvalid  = (lead != 1);
        // split writes also hold the response back for a cycle
        bready  = (lead == 0);
        while (!(aw_done && w_done) && n < WAIT_LIMIT)
        begin
            // ready seen now means the handshake happens at the next rising edge
            if (awvalid && awready)
                aw_done = 1'b1;
            if (wvalid && wready)
                w_done = 1'b1;
            @(negedge clk);
            awvalid = !aw_done;
            wvalid  = !w_done;
            n++;
        end
        while (!bvalid && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT)
            note_failure("write to the register block got no response");
        else if (bresp != 2'b00)
            note_failure("write response was not OKAY");
        if (!bready)
            @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        int n;
        n       = 0;
        data    = '0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            note_failure("read from the register block got no response");
        end
        else
        begin
            // one stalled cycle before the data is taken
            @(negedge clk);
            data = rdata;
            if (rresp != 2'b00)
                note_failure("read response was not OKAY");
            rready = 1'b1;
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic expect_reg(input axi_addr_t addr, input int expected, input string name);
        axi_data_t rd;
        axi_read(addr, rd);
        compare_value(name, int'(rd), expected);
    endtask

    task automatic push_sample(input int flux, input sample_t value);
        int n;
        n = 0;
        while (in_full[flux] && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            note_failure("input FIFO stayed full, sample skipped");
        end
        else
        begin
            in_write     = flux_mask_t'(1) << flux;
            in_din[flux] = value;
            @(negedge clk);
            in_write = '0;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (busy != '0 && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (busy != '0)
            note_failure("output streams did not drain");
    endtask

    task automatic open_phase(input int ph);
        case (ph)
            PH_BOUNDS:
            begin
                axi_write(REG_CLIP_LO, 32'd16, 1);
                axi_write(REG_CLIP_HI, 32'd235, 2);
                expect_reg(REG_CLIP_LO, 16, "clip_lo");
                expect_reg(REG_CLIP_HI, 235, "clip_hi");
            end
            PH_CROSSED:
            begin
                axi_write(REG_CLIP_LO, 32'd200, 2);
                axi_write(REG_CLIP_HI, 32'd100, 1);
                expect_reg(REG_CLIP_LO, 200, "clip_lo");
                expect_reg(REG_CLIP_HI, 100, "clip_hi");
            end
            PH_MASKED:
            begin
                // full range again so the held order stays visible
                axi_write(REG_CLIP_LO, 32'd0, 0);
                axi_write(REG_CLIP_HI, 32'd255, 0);
                axi_write(REG_CTRL, 32'd1, 0);
                expect_reg(REG_CTRL, 1, "enable");
                // flux 1 not popped, so any leaked pel stays visible
                out_read = flux_mask_t'(1);
            end
            PH_BACKPRESSURE:
                out_read = '0;
            PH_DEFAULT:
                out_read = '1;
        endcase
    endtask

    task automatic close_phase(input int ph);
        int   n;
        logic leak;
        n    = 0;
        leak = 1'b0;
        if (ph == PH_MASKED)
        begin
            while (busy[0] && n < WAIT_LIMIT)
            begin
                if (!out_empty[1])
                    leak = 1'b1;
                @(negedge clk);
                n++;
            end
            if (leak || !out_empty[1])
                note_failure("disabled flux 1 produced output");
            if (busy[0])
                note_failure("flux 0 did not drain while flux 1 was disabled");
            axi_write(REG_CTRL, 32'd3, 0);
            expect_reg(REG_CTRL, 3, "enable");
        end
        if (ph == PH_MASKED || ph == PH_BACKPRESSURE)
            out_read = '1;
        wait_drained();
    endtask

    initial
    begin
        int        cur_phase;
        int        bp_count;
        axi_data_t rd;
        tb_errors  = 0;
        in_write   = '0;
        in_din     = '0;
        out_read   = '1;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b1;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        finish_req = 1'b0;
        lcg_state  = 32'h34e5;
        rst_n      = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // state right after reset
        compare_value("in_full", int'(in_full), 0);
        compare_value("out_empty", int'(out_empty), (1 << FLUX) - 1);
        compare_value("bvalid", int'(bvalid), 0);
        compare_value("rvalid", int'(rvalid), 0);
        compare_value("awready", int'(awready), 1);
        compare_value("wready", int'(wready), 1);
        compare_value("arready", int'(arready), 1);
        expect_reg(REG_CTRL, (1 << FLUX) - 1, "enable");
        expect_reg(REG_CLIP_LO, 0, "clip_lo");
        expect_reg(REG_CLIP_HI, 255, "clip_hi");

        cur_phase = -1;
        bp_count  = 0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            if (TBL_PHASE[i] != cur_phase)
            begin
                close_phase(cur_phase);
                cur_phase = TBL_PHASE[i];
                bp_count  = 0;
                open_phase(cur_phase);
            end
            push_sample(TBL_FLUX[i], sample_t'(TBL_SAMPLE[i]));
            if (cur_phase == PH_BACKPRESSURE)
            begin
                bp_count++;
                compare_value("in_full", int'(in_full[TBL_FLUX[i]]),
                              int'(bp_count >= 2 * FIFO_DEPTH));
            end
        end
        close_phase(cur_phase);

        // random samples over the full signed range
        for (int n = 0; n < N_RANDOM; n++)
        begin
            lcg_state = lcg_step(lcg_state);
            push_sample(int'(lcg_state[31]), sample_t'(lcg_state[23:8]));
        end
        wait_drained();

        axi_read(REG_SAT_CNT, rd);
        compare_value("sat_count", int'(rd), int'(sat_expected));
        axi_write(REG_SAT_CNT, 32'd1, 0);
        expect_reg(REG_SAT_CNT, 0, "sat_count");

        finish_req = 1'b1;
        repeat (2) @(negedge clk);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // watchdog sized from the table and the random run
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors + 1);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sources.f
design/clip_pkg.sv
design/pel_fifo.sv
design/clip_actor.sv
design/clip_regs.sv
design/clip_top.sv
bench/clip_checker.sv
bench/clip_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the clip subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module clip_tb

./obj_dir/Vclip_tb 2>&1 | tee "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
